// ==== src/net_pkg.sv ====
package net_pkg;

  // Most significant octet sits at index 3.
  typedef logic [3:0][7:0] ipv4_t;

  // One payload byte of a UDP datagram.
  typedef struct packed {
    logic [7:0] data;
    logic       first;
    logic       last;
  } udp_beat_t;

  // Valid together with the first beat.
  typedef struct packed {
    ipv4_t       dst;
    logic [15:0] len; // Payload bytes.
  } udp_meta_t;

  localparam logic [15:0] DNS_PORT = 16'd53; // Server port for the UDP layer.

endpackage : net_pkg

// ==== src/dns_pkg.sv ====
package dns_pkg;

  localparam int NAME_MAX    = 32; // Widest host name in bytes.
  localparam int DNS_HDR_LEN = 12;

  localparam logic [15:0] QTYPE_A   = 16'd1;
  localparam logic [15:0] QCLASS_IN = 16'd1;
  localparam logic [15:0] FLAGS_RD  = 16'h0100; // Recursion desired.

  typedef struct packed {
    logic [15:0] id;
    logic [15:0] flags;
    logic [15:0] qdcount;
    logic [15:0] ancount;
    logic [15:0] nscount;
    logic [15:0] arcount;
  } dns_hdr_t;

  typedef enum logic [2:0] {
    idle_s,
    send_s,
    resp_wait_s,
    lease_s,
    fail_s
  } dns_state_e;

  typedef struct packed {
    logic [15:0]     id;
    logic            ok;
    logic [31:0]     ttl;
    net_pkg::ipv4_t  addr;
  } dns_rsp_t;

  // Name byte 0 is the first character, unused bytes at the top are zero.
  typedef struct packed {
    logic                      start;
    logic [NAME_MAX-1:0][7:0]  name;
    net_pkg::ipv4_t            server;
  } dns_ctl_t;

  typedef struct packed {
    logic            done;
    logic            ok;
    logic            addr_val;
    net_pkg::ipv4_t  addr;
    logic [31:0]     ttl;
  } dns_stat_t;

endpackage : dns_pkg

// ==== src/sec_tmr.sv ====
`timescale 1ns/1ps

module sec_tmr #(
  parameter int REFCLK_HZ = 125000000
) (
  input  logic clk,
  input  logic fsm_rst,
  input  logic en,
  output logic tick
);

  localparam int CW = $clog2(REFCLK_HZ + 1);
  localparam logic [CW-1:0] LAST = CW'(REFCLK_HZ - 1);

  logic [CW-1:0] cnt;

  assign tick = en && (cnt == LAST);

  // Held at zero while disabled so each wait starts a full second.
  always_ff @(posedge clk) begin
    if (fsm_rst || !en) begin
      cnt <= '0;
    end
    else if (cnt == LAST) begin
      cnt <= '0;
    end
    else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule : sec_tmr

// ==== src/dns_qry_enc.sv ====
`timescale 1ns/1ps

module dns_qry_enc #(
  parameter int NAME_LEN = 32
) (
  input  logic                     clk,
  input  logic                     fsm_rst,
  input  logic                     start,
  input  logic [15:0]              id,
  input  logic [NAME_LEN-1:0][7:0] name,
  input  net_pkg::ipv4_t           server,
  output net_pkg::udp_beat_t       tx,
  output logic                     tx_val,
  output net_pkg::udp_meta_t       tx_meta,
  output logic                     sent
);

  localparam int IW = $clog2(NAME_LEN + 1);

  typedef enum logic [1:0] {
    idle_e,
    asm_e,
    send_e
  } enc_state_e;

  enc_state_e state;

  logic [IW-1:0]            idx;
  logic [NAME_LEN+1:0][7:0] enc;     // Label form, count byte first.
  logic [7:0]               cur;
  logic [7:0]               lbl_cnt;
  logic [7:0]               lbl_nxt;
  logic                     seen;
  logic [15:0]              enc_len; // Encoded name incl. lead count and zero.
  logic [15:0]              pkt_len;
  logic [15:0]              bcnt;
  logic                     last_beat;
  logic [7:0]               byte_nxt;
  int                       ei;
  int                       ti;

  dns_pkg::dns_hdr_t                    hdr;
  logic [dns_pkg::DNS_HDR_LEN-1:0][7:0] hdr_b;
  logic [3:0][7:0]                      tail_b;

  assign hdr = '{id: id, flags: dns_pkg::FLAGS_RD, qdcount: 16'd1,
                 ancount: 16'd0, nscount: 16'd0, arcount: 16'd0};
  assign hdr_b  = hdr;
  assign tail_b = {dns_pkg::QTYPE_A, dns_pkg::QCLASS_IN};

  assign pkt_len   = 16'(dns_pkg::DNS_HDR_LEN) + enc_len + 16'd4;
  assign tx_meta   = '{dst: server, len: pkt_len};
  assign last_beat = (bcnt == pkt_len - 16'd1);

  assign cur = name[idx];

  always_comb begin
    if (cur == 8'h2e) lbl_nxt = 8'd0;           // A dot closes the label.
    else if (cur == 8'h00) lbl_nxt = lbl_cnt;
    else lbl_nxt = lbl_cnt + 8'd1;
  end

  // Header, encoded name, then type and class.
  always_comb begin
    ei = int'(bcnt) - dns_pkg::DNS_HDR_LEN;
    ti = ei - int'(enc_len);
    if (ei < 0) byte_nxt = hdr_b[dns_pkg::DNS_HDR_LEN - 1 - int'(bcnt)];
    else if (ti < 0) byte_nxt = enc[ei];
    else byte_nxt = tail_b[3 - ti];
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state  <= idle_e;
      tx_val <= 1'b0;
      sent   <= 1'b0;
    end
    else begin
      tx_val <= 1'b0;
      sent   <= 1'b0;
      case (state)
        idle_e : if (start) state <= asm_e;
        asm_e  : if (idx == '0) state <= send_e;
        send_e : begin
          tx_val <= 1'b1;
          sent   <= last_beat;
          if (last_beat) state <= idle_e;
        end
        default : state <= idle_e;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      idle_e : begin
        idx     <= IW'(NAME_LEN - 1);
        enc     <= '0;
        lbl_cnt <= 8'd0;
        seen    <= 1'b0;
        enc_len <= 16'd2;
        bcnt    <= 16'd0;
      end
      asm_e : begin
        enc[idx+1] <= (cur == 8'h2e) ? lbl_cnt : cur;
        lbl_cnt    <= lbl_nxt;
        if (!seen && cur != 8'h00) begin
          seen    <= 1'b1;
          enc_len <= 16'(idx) + 16'd3;
        end
        if (idx == '0) enc[0] <= lbl_nxt; // Count of the first label.
        else idx <= idx - 1'b1;
      end
      default : begin
        bcnt     <= bcnt + 16'd1;
        tx.data  <= byte_nxt;
        tx.first <= (bcnt == 16'd0);
        tx.last  <= last_beat;
      end
    endcase
  end

endmodule : dns_qry_enc

// ==== src/dns_rsp_parse.sv ====
`timescale 1ns/1ps

module dns_rsp_parse (
  input  logic               clk,
  input  logic               fsm_rst,
  input  net_pkg::udp_beat_t rx,
  input  logic               rx_val,
  output logic               rsp_val,
  output dns_pkg::dns_rsp_t  rsp
);

  typedef enum logic [2:0] {
    hdr_p,   // 12 header bytes.
    qname_p, // Question name up to its zero byte.
    qtail_p, // Question type and class.
    aname_p, // Compressed answer name.
    ans_p,   // Type, class, ttl, rdlength, rdata.
    done_p,
    err_p
  } parse_state_e;

  parse_state_e phase;
  parse_state_e cur_phase;
  logic [3:0]   cnt;
  logic [3:0]   cur_cnt;

  logic [dns_pkg::DNS_HDR_LEN-1:0][7:0] hdr_sr;
  logic [13:0][7:0]                     ans_sr;
  dns_pkg::dns_hdr_t                    hdr;
  logic [15:0]                          a_type;
  logic [15:0]                          a_class;
  logic [31:0]                          a_ttl;
  logic [15:0]                          a_rdlen;
  net_pkg::ipv4_t                       a_addr;
  logic                                 ok;

  // A first beat always restarts the walk.
  assign cur_phase = rx.first ? hdr_p : phase;
  assign cur_cnt   = rx.first ? 4'd0 : cnt;

  assign hdr     = hdr_sr;
  assign a_type  = ans_sr[13:12];
  assign a_class = ans_sr[11:10];
  assign a_ttl   = ans_sr[9:6];
  assign a_rdlen = ans_sr[5:4];
  assign a_addr  = ans_sr[3:0];

  assign ok = (phase == done_p) && hdr.flags[15] && (hdr.flags[3:0] == 4'd0) &&
              (hdr.ancount != 16'd0) && (a_type == dns_pkg::QTYPE_A) &&
              (a_class == dns_pkg::QCLASS_IN) && (a_rdlen == 16'd4);

  assign rsp = '{id: hdr.id, ok: ok, ttl: a_ttl, addr: a_addr};

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      phase   <= hdr_p;
      cnt     <= 4'd0;
      rsp_val <= 1'b0;
    end
    else begin
      rsp_val <= rx_val && rx.last;
      if (rx_val) begin
        cnt   <= cur_cnt + 4'd1;
        phase <= cur_phase;
        case (cur_phase)
          hdr_p : begin
            if (cur_cnt == 4'd11) begin
              phase <= qname_p;
              cnt   <= 4'd0;
            end
          end
          qname_p : begin
            if (rx.data == 8'h00) begin
              phase <= qtail_p;
              cnt   <= 4'd0;
            end
          end
          qtail_p : begin
            if (cur_cnt == 4'd3) begin
              phase <= aname_p;
              cnt   <= 4'd0;
            end
          end
          aname_p : begin
            if (cur_cnt == 4'd0 && rx.data[7:6] != 2'b11) begin
              phase <= err_p; // Only a pointer is accepted here.
            end
            else if (cur_cnt == 4'd1) begin
              phase <= ans_p;
              cnt   <= 4'd0;
            end
          end
          ans_p : if (cur_cnt == 4'd13) phase <= done_p;
          default : cnt <= 4'd0; // Trailing records are dropped.
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_val && cur_phase == hdr_p) hdr_sr <= {hdr_sr[10:0], rx.data};
    if (rx_val && cur_phase == ans_p) ans_sr <= {ans_sr[12:0], rx.data};
  end

endmodule : dns_rsp_parse

// ==== src/dns_core.sv ====
`timescale 1ns/1ps

module dns_core #(
  parameter int NAME_LEN    = 32,
  parameter int RETRIES     = 3,
  parameter int TIMEOUT_SEC = 2,
  parameter int LEASE_SEC   = 5
) (
  input  logic                     clk,
  input  logic                     fsm_rst,
  input  dns_pkg::dns_ctl_t        ctl,
  output dns_pkg::dns_stat_t       stat,
  output logic                     enc_start,
  output logic [15:0]              qry_id,
  output logic [NAME_LEN-1:0][7:0] qry_name,
  output net_pkg::ipv4_t           qry_server,
  input  logic                     sent,
  input  logic                     rsp_val,
  input  dns_pkg::dns_rsp_t        rsp,
  output logic                     tmr_en,
  input  logic                     tick
);

  localparam int FW = $clog2(RETRIES + 1);
  localparam int SEC_MAX = (TIMEOUT_SEC > LEASE_SEC) ? TIMEOUT_SEC : LEASE_SEC;
  localparam int SW = $clog2(SEC_MAX + 1);

  localparam logic [FW-1:0] FAIL_LAST = FW'(RETRIES - 1);
  localparam logic [SW-1:0] TMO_LAST  = SW'(TIMEOUT_SEC - 1);
  localparam logic [SW-1:0] LEASE_END = SW'(LEASE_SEC - 1);

  dns_pkg::dns_state_e state;

  logic [FW-1:0] fail_cnt;
  logic [SW-1:0] sec_cnt;
  logic          launch;
  logic          rsp_hit;
  logic          fail_evt;

  assign launch = ctl.start && (state == dns_pkg::idle_s || state == dns_pkg::lease_s ||
                                state == dns_pkg::fail_s);

  // Responses for an older query are dropped without touching the timeout.
  assign rsp_hit  = rsp_val && (rsp.id == qry_id) && (state == dns_pkg::resp_wait_s);
  assign fail_evt = (rsp_hit && !rsp.ok) ||
                    (state == dns_pkg::resp_wait_s && tick && sec_cnt == TMO_LAST);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state         <= dns_pkg::idle_s;
      qry_id        <= 16'h0000; // First attempt uses 1.
      fail_cnt      <= '0;
      sec_cnt       <= '0;
      enc_start     <= 1'b0;
      tmr_en        <= 1'b0;
      stat.done     <= 1'b0;
      stat.ok       <= 1'b0;
      stat.addr_val <= 1'b0;
    end
    else begin
      enc_start <= 1'b0;
      tmr_en    <= 1'b0;
      stat.done <= 1'b0;
      if (launch) begin
        qry_name      <= ctl.name[NAME_LEN-1:0];
        qry_server    <= ctl.server;
        qry_id        <= qry_id + 16'd1;
        fail_cnt      <= '0;
        enc_start     <= 1'b1;
        stat.addr_val <= 1'b0;
        state         <= dns_pkg::send_s;
      end
      else begin
        case (state)
          dns_pkg::send_s : begin
            sec_cnt <= '0;
            if (sent) state <= dns_pkg::resp_wait_s;
          end
          dns_pkg::resp_wait_s : begin
            tmr_en <= 1'b1;
            if (rsp_hit && rsp.ok) begin
              tmr_en        <= 1'b0; // Restart the second for the lease.
              sec_cnt       <= '0;
              stat.done     <= 1'b1;
              stat.ok       <= 1'b1;
              stat.addr_val <= 1'b1;
              stat.addr     <= rsp.addr;
              stat.ttl      <= rsp.ttl;
              state         <= dns_pkg::lease_s;
            end
            else if (fail_evt) begin
              tmr_en <= 1'b0;
              if (fail_cnt == FAIL_LAST) begin
                stat.done <= 1'b1;
                stat.ok   <= 1'b0;
                state     <= dns_pkg::fail_s;
              end
              else begin
                fail_cnt  <= fail_cnt + 1'b1;
                qry_id    <= qry_id + 16'd1;
                enc_start <= 1'b1;
                state     <= dns_pkg::send_s;
              end
            end
            else if (tick) begin
              sec_cnt <= sec_cnt + 1'b1;
            end
          end
          dns_pkg::lease_s : begin
            tmr_en <= 1'b1;
            if (tick) begin
              sec_cnt <= sec_cnt + 1'b1;
              if (sec_cnt == LEASE_END) begin
                tmr_en        <= 1'b0;
                stat.addr_val <= 1'b0;
                state         <= dns_pkg::idle_s;
              end
            end
          end
          default : ; // Idle and fail wait for start.
        endcase
      end
    end
  end

endmodule : dns_core

// ==== src/dns_client.sv ====
`timescale 1ns/1ps

module dns_client #(
  parameter int NAME_LEN    = 32,
  parameter int RETRIES     = 3,
  parameter int TIMEOUT_SEC = 2,
  parameter int LEASE_SEC   = 5,
  parameter int REFCLK_HZ   = 125000000
) (
  input  logic               clk,
  input  logic               fsm_rst,
  input  dns_pkg::dns_ctl_t  ctl,
  output dns_pkg::dns_stat_t stat,
  output net_pkg::udp_beat_t tx,
  output logic               tx_val,
  output net_pkg::udp_meta_t tx_meta,
  input  net_pkg::udp_beat_t rx,
  input  logic               rx_val
);

  logic                     enc_start;
  logic [15:0]              qry_id;
  logic [NAME_LEN-1:0][7:0] qry_name;
  net_pkg::ipv4_t           qry_server;
  logic                     sent;
  logic                     rsp_val;
  dns_pkg::dns_rsp_t        rsp;
  logic                     tmr_en;
  logic                     tick;

  dns_core #(
    .NAME_LEN    (NAME_LEN),
    .RETRIES     (RETRIES),
    .TIMEOUT_SEC (TIMEOUT_SEC),
    .LEASE_SEC   (LEASE_SEC)
  ) u_core (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .ctl        (ctl),
    .stat       (stat),
    .enc_start  (enc_start),
    .qry_id     (qry_id),
    .qry_name   (qry_name),
    .qry_server (qry_server),
    .sent       (sent),
    .rsp_val    (rsp_val),
    .rsp        (rsp),
    .tmr_en     (tmr_en),
    .tick       (tick)
  );

  dns_qry_enc #(
    .NAME_LEN (NAME_LEN)
  ) u_enc (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .start   (enc_start),
    .id      (qry_id),
    .name    (qry_name),
    .server  (qry_server),
    .tx      (tx),
    .tx_val  (tx_val),
    .tx_meta (tx_meta),
    .sent    (sent)
  );

  dns_rsp_parse u_parse (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .rx      (rx),
    .rx_val  (rx_val),
    .rsp_val (rsp_val),
    .rsp     (rsp)
  );

  sec_tmr #(
    .REFCLK_HZ (REFCLK_HZ)
  ) u_tmr (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .en      (tmr_en),
    .tick    (tick)
  );

endmodule : dns_client

// ==== test/tb_dns_client.sv ====
`timescale 1ns/1ps

module tb_dns_client;

  localparam int NAME_LEN    = dns_pkg::NAME_MAX;
  localparam int RETRIES     = 3;
  localparam int TIMEOUT_SEC = 2;
  localparam int LEASE_SEC   = 5;
  localparam int REFCLK_HZ   = 50;
  localparam int PKT_MAX     = 128;

  localparam int SEC_CYC     = REFCLK_HZ;
  localparam int QRY_CYC     = NAME_LEN + PKT_MAX + 8;       // Start to last query beat.
  localparam int ATTEMPT_CYC = (TIMEOUT_SEC + 1) * SEC_CYC + QRY_CYC;
  localparam int FAST_CYC    = NAME_LEN + 40;                 // Well inside one timeout.
  localparam int LEASE_MIN   = (LEASE_SEC - 1) * SEC_CYC;
  localparam int LEASE_MAX   = (LEASE_SEC + 1) * SEC_CYC;
  // Lookups, one lease, one retry run and the checks after it, plus margin.
  localparam int BUDGET_CYC  = 12 * (QRY_CYC + 2 * PKT_MAX) + LEASE_MAX +
                               (RETRIES + 2) * ATTEMPT_CYC + 500;

  typedef logic [dns_pkg::NAME_MAX-1:0][7:0] name_t;
  typedef logic [PKT_MAX-1:0][7:0] pkt_t;

  logic                clk;
  logic                fsm_rst;
  dns_pkg::dns_ctl_t   ctl;
  dns_pkg::dns_stat_t  stat;
  net_pkg::udp_beat_t  tx;
  logic                tx_val;
  net_pkg::udp_meta_t  tx_meta;
  net_pkg::udp_beat_t  rx;
  logic                rx_val;

  integer          seed;
  name_t           ref_name;
  net_pkg::ipv4_t  ref_server;
  logic [15:0]     exp_id = 16'h0001; // Next query ID the DUT must use.
  logic [15:0]     last_id = 16'h0000;
  int              qry_cnt = 0;
  int              cap_len = 0;
  pkt_t            cap_pkt;
  pkt_t            exp_pkt;
  int              exp_len;

  dns_client #(
    .NAME_LEN    (NAME_LEN),
    .RETRIES     (RETRIES),
    .TIMEOUT_SEC (TIMEOUT_SEC),
    .LEASE_SEC   (LEASE_SEC),
    .REFCLK_HZ   (REFCLK_HZ)
  ) u_dut (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .ctl     (ctl),
    .stat    (stat),
    .tx      (tx),
    .tx_val  (tx_val),
    .tx_meta (tx_meta),
    .rx      (rx),
    .rx_val  (rx_val)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp) else
      report_fail($sformatf("error: %s is %h, expected %h", what, got, exp));
  endtask

  // Header, labels with their counts, zero byte, then type A and class IN.
  function automatic void build_query(input name_t nm, input logic [15:0] id,
                                      output pkt_t pkt, output int len);
    int n;
    int s;
    int i;
    int j;
    pkt = '0;
    n = 0;
    while (n < dns_pkg::NAME_MAX && nm[n] != 8'h00) n++;
    pkt[0] = id[15:8];
    pkt[1] = id[7:0];
    pkt[2] = 8'h01; // Recursion desired.
    pkt[5] = 8'h01; // One question.
    len = 12;
    s = 0;
    for (i = 0; i <= n; i++) begin
      if (i == n || nm[i] == 8'h2e) begin
        pkt[len] = 8'(i - s);
        len++;
        for (j = s; j < i; j++) begin
          pkt[len] = nm[j];
          len++;
        end
        s = i + 1;
      end
    end
    pkt[len + 2] = 8'h01;
    pkt[len + 4] = 8'h01;
    len = len + 5;
  endfunction

  function automatic void build_response(input name_t nm, input logic [15:0] id,
                                         input logic [3:0] rcode, input net_pkg::ipv4_t addr,
                                         input logic [31:0] ttl, output pkt_t pkt,
                                         output int len);
    logic [15:0][7:0] ans;
    int k;
    build_query(nm, id, pkt, len);
    pkt[2] = 8'h81;          // QR and RD.
    pkt[3] = {4'h8, rcode};
    pkt[7] = 8'h01;          // One answer.
    ans = {16'hc00c, 16'h0001, 16'h0001, ttl, 16'h0004, addr};
    for (k = 0; k < 16; k++) pkt[len + k] = ans[15 - k];
    len = len + 16;
  endfunction

  function automatic name_t str_to_name(input string s);
    name_t nm;
    int i;
    nm = '0;
    for (i = 0; i < s.len(); i++) nm[i] = s[i];
    return nm;
  endfunction

  task automatic make_random_name(output name_t nm);
    int labels;
    int chars;
    int pos;
    int l;
    int k;
    nm = '0;
    pos = 0;
    labels = 1 + int'($unsigned($random(seed)) % 3);
    for (l = 0; l < labels; l++) begin
      if (l > 0) begin
        nm[pos] = 8'h2e;
        pos++;
      end
      chars = 1 + int'($unsigned($random(seed)) % 8);
      for (k = 0; k < chars; k++) begin
        nm[pos] = 8'h61 + 8'($unsigned($random(seed)) % 26);
        pos++;
      end
    end
  endtask

  // Server side capture. Every finished query is checked against the reference.
  always @(negedge clk) begin : capture
    int k;
    if (!fsm_rst && tx_val) begin
      if (cap_len == 0) begin
        build_query(ref_name, exp_id, exp_pkt, exp_len);
        expect_eq("tx_meta.len", 32'(tx_meta.len), 32'(exp_len));
        expect_eq("tx_meta.dst", tx_meta.dst, ref_server);
      end
      expect_eq("tx.first", 32'(tx.first), 32'(cap_len == 0));
      expect_eq("tx.last", 32'(tx.last), 32'(cap_len == exp_len - 1));
      cap_pkt[cap_len] = tx.data;
      cap_len = cap_len + 1;
      if (tx.last) begin
        for (k = 0; k < exp_len; k++) begin
          expect_eq($sformatf("tx.data[%0d]", k), 32'(cap_pkt[k]), 32'(exp_pkt[k]));
        end
        last_id = exp_id;
        exp_id  = exp_id + 16'd1;
        qry_cnt = qry_cnt + 1;
        cap_len = 0;
      end
    end
  end

  task automatic send_response(input logic [15:0] id, input logic [3:0] rcode,
                               input net_pkg::ipv4_t addr, input logic [31:0] ttl);
    pkt_t pkt;
    int len;
    int k;
    build_response(ref_name, id, rcode, addr, ttl, pkt, len);
    for (k = 0; k < len; k++) begin
      @(posedge clk);
      rx     <= '{data: pkt[k], first: (k == 0), last: (k == len - 1)};
      rx_val <= 1'b1;
    end
    @(posedge clk);
    rx     <= '0;
    rx_val <= 1'b0;
  endtask

  task automatic start_query(input name_t nm, input net_pkg::ipv4_t srv);
    ref_name   = nm;
    ref_server = srv;
    @(posedge clk);
    ctl <= '{start: 1'b1, name: nm, server: srv};
    @(posedge clk);
    ctl.start <= 1'b0;
  endtask

  task automatic wait_queries(input int n, input int limit);
    int c;
    c = 0;
    while (qry_cnt < n && c <= limit) begin
      @(posedge clk);
      c++;
    end
    assert (qry_cnt >= n) else report_fail("a query did not appear on tx in time");
  endtask

  task automatic wait_done(input int limit);
    int c;
    c = 0;
    @(negedge clk);
    while (!stat.done && c < limit) begin
      @(negedge clk);
      c++;
    end
    assert (stat.done) else report_fail("done did not pulse in time");
  endtask

  task automatic check_success(input net_pkg::ipv4_t addr, input logic [31:0] ttl);
    expect_eq("stat.ok", 32'(stat.ok), 32'd1);
    expect_eq("stat.addr", stat.addr, addr);
    expect_eq("stat.ttl", stat.ttl, ttl);
    expect_eq("stat.addr_val", 32'(stat.addr_val), 32'd1);
  endtask

  task automatic run_lookup(input name_t nm);
    net_pkg::ipv4_t srv;
    net_pkg::ipv4_t addr;
    logic [31:0]    ttl;
    int             n;
    srv  = $random(seed);
    addr = $random(seed);
    ttl  = $random(seed);
    n    = qry_cnt;
    start_query(nm, srv);
    wait_queries(n + 1, QRY_CYC);
    send_response(last_id, 4'd0, addr, ttl);
    wait_done(SEC_CYC);
    check_success(addr, ttl);
  endtask

  initial begin
    repeat (BUDGET_CYC) @(posedge clk);
    report_fail("simulation ran past its cycle budget");
  end

  initial begin : main
    name_t          nm;
    net_pkg::ipv4_t srv;
    net_pkg::ipv4_t addr;
    logic [31:0]    ttl;
    int             i;
    int             n;
    int             hi;
    seed    = 32'h6f0d_3117;
    fsm_rst = 1'b1;
    ctl     = '0;
    rx      = '0;
    rx_val  = 1'b0;
    repeat (5) @(posedge clk);
    fsm_rst <= 1'b0;
    @(negedge clk);
    expect_eq("tx_val", 32'(tx_val), 32'd0);
    expect_eq("stat.done", 32'(stat.done), 32'd0);
    expect_eq("stat.addr_val", 32'(stat.addr_val), 32'd0);
    expect_eq("rsp_val", 32'(u_dut.rsp_val), 32'd0);
    expect_eq("u_core.state", 32'(u_dut.u_core.state), 32'(dns_pkg::idle_s));

    // Encoding and resolution; each new start lands in the lease of the last one.
    run_lookup(str_to_name("a"));
    run_lookup(str_to_name("www.example.com"));
    run_lookup(str_to_name("x.y.z"));
    for (i = 0; i < 3; i++) begin
      make_random_name(nm);
      run_lookup(nm);
    end

    hi = 0;
    while (stat.addr_val && hi <= LEASE_MAX) begin
      @(negedge clk);
      hi++;
    end
    assert (!stat.addr_val) else report_fail("addr_val stayed high past the lease");
    assert (hi >= LEASE_MIN) else
      report_fail($sformatf("error: addr_val high for %h cycles, expected at least %h",
                            hi, LEASE_MIN));

    // No server answer at all.
    srv = $random(seed);
    n   = qry_cnt;
    start_query(str_to_name("retry.example.net"), srv);
    wait_queries(n + RETRIES, RETRIES * ATTEMPT_CYC);
    wait_done(ATTEMPT_CYC);
    expect_eq("stat.ok", 32'(stat.ok), 32'd0);
    expect_eq("stat.addr_val", 32'(stat.addr_val), 32'd0);
    repeat (ATTEMPT_CYC) @(posedge clk);
    expect_eq("query count", 32'(qry_cnt), 32'(n + RETRIES));

    // Stale ID first, then the real answer.
    srv  = $random(seed);
    addr = $random(seed);
    ttl  = $random(seed);
    n    = qry_cnt;
    start_query(str_to_name("ab.c"), srv);
    wait_queries(n + 1, QRY_CYC);
    send_response(last_id + 16'h0100, 4'd0, ~addr, ttl);
    send_response(last_id, 4'd0, addr, ttl);
    wait_done(SEC_CYC);
    check_success(addr, ttl);
    expect_eq("query count", 32'(qry_cnt), 32'(n + 1));

    // Server error code forces a retry long before the timeout.
    srv  = $random(seed);
    addr = $random(seed);
    ttl  = $random(seed);
    n    = qry_cnt;
    start_query(str_to_name("ns.io"), srv);
    wait_queries(n + 1, QRY_CYC);
    send_response(last_id, 4'd3, addr, ttl);
    wait_queries(n + 2, FAST_CYC);
    send_response(last_id, 4'd0, addr, ttl);
    wait_done(SEC_CYC);
    check_success(addr, ttl);

    $display("** PASS **");
    $finish;
  end

endmodule : tb_dns_client

// ==== dns_client.f ====
src/net_pkg.sv
src/dns_pkg.sv
src/sec_tmr.sv
src/dns_qry_enc.sv
src/dns_rsp_parse.sv
src/dns_core.sv
src/dns_client.sv
test/tb_dns_client.sv

// ==== Makefile ====
TOP := tb_dns_client

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f dns_client.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q '^\*\* PASS \*\*$$'

clean:
	rm -rf obj_dir

.PHONY: sim clean
